//--- src.f
+incdir+source
source/rv_ex_pkg.sv
source/id_ex_if.sv
source/id_stage.sv
source/id_ex_reg.sv
source/ex_stage.sv
source/ex_unit_top.sv
sim/ex_unit_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = ex_unit_tb
FILELIST  = src.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -F -q '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- sim/ex_unit_tb.sv
`timescale 1ns/10ps
`include "rv_ex_cfg.svh"

module ex_unit_tb;

   import rv_ex_pkg::*;

   localparam int CLK_HALF = 4;                // 8 ns period
   localparam int RST_CYC  = 5;
   localparam int N_INST   = 600;
   localparam int SEED     = 52502;
   // three cycles per item at worst plus reset and drain
   localparam int TIMEOUT  = (N_INST * 3 + RST_CYC + 40) * 2 * CLK_HALF;

   // ####################
   // kinds 0..9 follow the r-type alu table
   localparam int K_LW   = 10;
   localparam int K_SW   = 11;
   localparam int K_JAL  = 12;
   localparam int K_JALR = 13;
   localparam int K_BAD  = 14;

   typedef struct packed {
      int        seq;
      int        kind;
      logic      imm;
      int        due;                          // cycle of the result
      reg_addr_t wd;
      logic      wreg;
      word_t     wdata;
      memop_t    memop;
      word_t     addr;
      word_t     sdata;
   } exp_t;

   logic      clk_i = 1'b0;
   logic      rst_n_i;
   logic      inst_valid_i;
   word_t     inst_i;
   word_t     pc_i;
   word_t     rs1_data_i;
   word_t     rs2_data_i;
   logic      res_valid_o;
   reg_addr_t res_wd_o;
   logic      res_wreg_o;
   word_t     res_wdata_o;
   memop_t    mem_op_o;
   word_t     mem_addr_o;
   word_t     mem_wdata_o;

   exp_t      exp_q[$];                        // model results in issue order
   int        cyc = 0;                         // rising edges seen
   int        err_val;
   int        err_proto;
   logic      mon_en;

   ex_unit_top ex_unit_top_i
     (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .inst_valid_i (inst_valid_i),
      .inst_i       (inst_i),
      .pc_i         (pc_i),
      .rs1_data_i   (rs1_data_i),
      .rs2_data_i   (rs2_data_i),
      .res_valid_o  (res_valid_o),
      .res_wd_o     (res_wd_o),
      .res_wreg_o   (res_wreg_o),
      .res_wdata_o  (res_wdata_o),
      .mem_op_o     (mem_op_o),
      .mem_addr_o   (mem_addr_o),
      .mem_wdata_o  (mem_wdata_o)
      );

   always #(CLK_HALF) clk_i = ~clk_i;

   always @(posedge clk_i)
      cyc <= cyc + 1;

   // ####################
   // reference model
   function automatic word_t alu_ref(int op, word_t a, word_t b);
      case (op)
         0:       return a + b;
         1:       return a - b;
         2:       return a << b[4:0];
         3:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         4:       return (a < b) ? 32'd1 : 32'd0;
         5:       return a ^ b;
         6:       return a >> b[4:0];
         7:       return word_t'($signed(a) >>> b[4:0]); // sign fill
         8:       return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic [2:0] funct3_of(int op);
      case (op)
         0, 1:    return 3'd0;
         2:       return 3'd1;
         3:       return 3'd2;
         4:       return 3'd3;
         5:       return 3'd4;
         6, 7:    return 3'd5;
         8:       return 3'd6;
         default: return 3'd7;
      endcase
   endfunction

   function automatic logic [6:0] funct7_of(int op);
      return (op == 1 || op == 7) ? 7'h20 : 7'h00; // sub, sra
   endfunction

   function automatic word_t sext12(logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   function automatic string op_name(int kind, logic imm);
      string s;
      case (kind)
         0:       s = "add";
         1:       s = "sub";
         2:       s = "sll";
         3:       s = "slt";
         4:       s = "sltu";
         5:       s = "xor";
         6:       s = "srl";
         7:       s = "sra";
         8:       s = "or";
         9:       s = "and";
         K_LW:    s = "lw";
         K_SW:    s = "sw";
         K_JAL:   s = "jal";
         K_JALR:  s = "jalr";
         default: s = "unsupported";
      endcase
      if (imm)
         s = (kind == 4) ? "sltiu" : {s, "i"};
      return s;
   endfunction

   // ####################
   // operand picks with frequent corner values
   function automatic word_t pick_val();
      case ($urandom_range(0, 7))
         0:       return 32'h0000_0000;
         1:       return 32'h8000_0000;     // most negative
         2:       return 32'h7fff_ffff;
         3:       return 32'hffff_ffff;     // shift amount 31 too
         4:       return word_t'($urandom_range(0, 31));
         default: return word_t'($urandom);
      endcase
   endfunction

   function automatic logic [11:0] pick_imm();
      case ($urandom_range(0, 5))
         0:       return 12'h000;
         1:       return 12'h7ff;
         2:       return 12'h800;           // most negative offset
         3:       return 12'hfff;
         default: return 12'($urandom);
      endcase
   endfunction

   // ####################
   // compare tasks
   task automatic check_word(string name, word_t exp, word_t act);
      if (act !== exp)
      begin
         err_val++;
         $display("ERR %s expected %08h actual %08h", name, exp, act);
      end
   endtask

   task automatic check_addr(string name, reg_addr_t exp, reg_addr_t act);
      if (act !== exp)
      begin
         err_val++;
         $display("ERR %s expected x%0d actual x%0d", name, exp, act);
      end
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (act !== exp)
      begin
         err_val++;
         $display("ERR %s expected %b actual %b", name, exp, act);
      end
   endtask

   task automatic check_memop(string name, memop_t exp, memop_t act);
      if (act !== exp)
      begin
         err_val++;
         $display("ERR %s expected %b actual %b", name, exp, act);
      end
   endtask

   // ####################
   // stimulus
   task automatic drive_idle();
      inst_valid_i = 1'b0;
      inst_i       = word_t'($urandom);   // junk while idle
      pc_i         = word_t'($urandom);
      rs1_data_i   = word_t'($urandom);
      rs2_data_i   = word_t'($urandom);
   endtask

   task automatic issue_one(int seq);
      exp_t        e;
      int          kind;
      logic        imm;
      logic [11:0] imm12;
      logic [4:0]  sh;
      logic [6:0]  bad_opc;
      reg_addr_t   rd;
      reg_addr_t   ra;
      reg_addr_t   rb;
      word_t       a;
      word_t       b;
      word_t       pc;
      word_t       inst;
      kind  = int'($urandom_range(0, K_BAD));
      imm   = (kind < K_LW) && (kind != 1) && ($urandom_range(0, 1) == 1); // no subi
      imm12 = pick_imm();
      case ($urandom_range(0, 3))
         0:       sh = 5'd0;
         1:       sh = 5'd31;
         default: sh = 5'($urandom);
      endcase
      rd = reg_addr_t'($urandom);
      ra = reg_addr_t'($urandom);
      rb = reg_addr_t'($urandom);
      a  = pick_val();
      b  = ($urandom_range(0, 3) == 0) ? a : pick_val(); // equal operands now and then
      pc = word_t'($urandom) & 32'hffff_fffc;
      e       = '0;
      e.seq   = seq;
      e.kind  = kind;
      e.imm   = imm;
      e.due   = cyc + 2;                   // id/ex at the next edge, ex/mem one edge later
      e.wd    = rd;
      e.sdata = b;
      e.memop = `RV_MEM_NONE;
      case (kind)
         K_LW:
         begin
            inst    = {imm12, ra, 3'b010, rd, `RV_OPC_LOAD};
            e.wreg  = 1'b1;
            e.memop = `RV_MEM_LOAD;
            e.addr  = a + sext12(imm12);
         end
         K_SW:
         begin
            inst    = {imm12[11:5], rb, ra, 3'b010, imm12[4:0], `RV_OPC_STORE};
            e.memop = `RV_MEM_STORE;
            e.addr  = a + sext12(imm12);
         end
         K_JAL:
         begin
            inst    = {20'($urandom), rd, `RV_OPC_JAL};
            e.wreg  = 1'b1;
            e.wdata = pc + 32'd4;
         end
         K_JALR:
         begin
            inst    = {imm12, ra, 3'b000, rd, `RV_OPC_JALR};
            e.wreg  = 1'b1;
            e.wdata = pc + 32'd4;
         end
         K_BAD:
         begin
            case ($urandom_range(0, 3))
               0:       bad_opc = 7'b0110111;  // lui
               1:       bad_opc = 7'b0010111;  // auipc
               2:       bad_opc = 7'b1100011;  // branch
               default: bad_opc = 7'b1110011;  // system
            endcase
            inst = {25'($urandom), bad_opc};
         end
         default:
         begin
            e.wreg = 1'b1;
            if (!imm)
            begin
               inst    = {funct7_of(kind), rb, ra, funct3_of(kind), rd, `RV_OPC_OP};
               e.wdata = alu_ref(kind, a, b);
            end
            else if (kind == 2 || kind == 6 || kind == 7)
            begin
               inst    = {funct7_of(kind), sh, ra, funct3_of(kind), rd, `RV_OPC_OP_IMM};
               e.wdata = alu_ref(kind, a, {27'd0, sh});
            end
            else
            begin
               inst    = {imm12, ra, funct3_of(kind), rd, `RV_OPC_OP_IMM};
               e.wdata = alu_ref(kind, a, sext12(imm12));
            end
         end
      endcase
      inst_valid_i = 1'b1;
      inst_i       = inst;
      pc_i         = pc;
      rs1_data_i   = a;
      rs2_data_i   = b;
      exp_q.push_back(e);
   endtask

   // ####################
   // result monitor at mid cycle
   task automatic check_cycle();
      exp_t  e;
      string name;
      if (res_valid_o)
      begin
         if (exp_q.size() == 0)
         begin
            err_proto++;
            $display("result valid in cycle %0d with no instruction pending", cyc);
         end
         else
         begin
            e = exp_q.pop_front();
            if (e.due != cyc)
            begin
               err_proto++;
               $display("item %0d gave its result in cycle %0d instead of cycle %0d",
                        e.seq, cyc, e.due);
            end
            name = $sformatf("#%0d %s", e.seq, op_name(e.kind, e.imm));
            check_bit({name, " wreg"}, e.wreg, res_wreg_o);
            if (e.wreg)
               check_addr({name, " wd"}, e.wd, res_wd_o);
            check_word({name, " wdata"}, e.wdata, res_wdata_o);
            check_memop({name, " mem_op"}, e.memop, mem_op_o);
            if (e.memop != `RV_MEM_NONE)
               check_word({name, " mem_addr"}, e.addr, mem_addr_o);
            if (e.memop == `RV_MEM_STORE)
               check_word({name, " mem_wdata"}, e.sdata, mem_wdata_o);
         end
      end
      else
      begin
         if (exp_q.size() != 0 && exp_q[0].due <= cyc)
         begin
            e = exp_q.pop_front();
            err_proto++;
            $display("no result for item %0d (%s) in cycle %0d",
                     e.seq, op_name(e.kind, e.imm), cyc);
         end
         name = $sformatf("idle cycle %0d", cyc);
         check_bit({name, " wreg"}, 1'b0, res_wreg_o);
         check_memop({name, " mem_op"}, `RV_MEM_NONE, mem_op_o);
      end
   endtask

   always @(negedge clk_i)
   begin
      if (mon_en)
         check_cycle();
   end

   // ####################
   // main sequence
   initial
   begin
      int gap;
      void'($urandom(SEED));
      rst_n_i      = 1'b0;
      inst_valid_i = 1'b0;
      inst_i       = '0;
      pc_i         = '0;
      rs1_data_i   = '0;
      rs2_data_i   = '0;
      err_val      = 0;
      err_proto    = 0;
      mon_en       = 1'b0;
      repeat (RST_CYC) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      mon_en  = 1'b1;                        // reset values checked from here
      repeat (3)
      begin
         drive_idle();
         @(posedge clk_i);
         #1;
      end
      for (int i = 0; i < N_INST; i++)
      begin
         issue_one(i);
         @(posedge clk_i);
         #1;
         gap = ($urandom_range(0, 1) == 0) ? 0 : int'($urandom_range(1, 2));
         repeat (gap)
         begin
            drive_idle();
            @(posedge clk_i);
            #1;
         end
      end
      drive_idle();
      while (exp_q.size() != 0)
         @(posedge clk_i);
      repeat (4) @(posedge clk_i);           // catch stray valids
      $display("errors: %0d value, %0d protocol", err_val, err_proto);
      if (err_val == 0 && err_proto == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

   // watchdog
   initial
   begin
      #(TIMEOUT);
      $display("timeout: run did not finish within %0d ns", TIMEOUT);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

//--- source/ex_unit_top.sv
`timescale 1ns/10ps

module ex_unit_top
  (
   input  logic                  clk_i,
   input  logic                  rst_n_i,      // sync, active low

   // issue side
   input  logic                  inst_valid_i, // one-cycle strobe
   input  rv_ex_pkg::word_t      inst_i,
   input  rv_ex_pkg::word_t      pc_i,
   input  rv_ex_pkg::word_t      rs1_data_i,
   input  rv_ex_pkg::word_t      rs2_data_i,

   // ex/mem side, 2 cycles after the strobe
   output logic                  res_valid_o,
   output rv_ex_pkg::reg_addr_t  res_wd_o,
   output logic                  res_wreg_o,
   output rv_ex_pkg::word_t      res_wdata_o,
   output rv_ex_pkg::memop_t     mem_op_o,
   output rv_ex_pkg::word_t      mem_addr_o,
   output rv_ex_pkg::word_t      mem_wdata_o
   );

   id_ex_if dec_if ();  // decoder -> pipeline reg
   id_ex_if exe_if ();  // pipeline reg -> execute

   // ####################
   // decode, combinational
   id_stage id_stage_i
     (
      .inst_valid_i (inst_valid_i),
      .inst_i       (inst_i),
      .pc_i         (pc_i),
      .rs1_data_i   (rs1_data_i),
      .rs2_data_i   (rs2_data_i),
      .dec_o        (dec_if.src)
      );

   // id/ex register, 1 cycle
   id_ex_reg id_ex_reg_i
     (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .dec_i   (dec_if.dst),
      .exe_o   (exe_if.src)
      );

   // ####################
   // execute, registered outputs
   ex_stage ex_stage_i
     (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .exe_i       (exe_if.dst),
      .res_valid_o (res_valid_o),
      .res_wd_o    (res_wd_o),
      .res_wreg_o  (res_wreg_o),
      .res_wdata_o (res_wdata_o),
      .mem_op_o    (mem_op_o),
      .mem_addr_o  (mem_addr_o),
      .mem_wdata_o (mem_wdata_o)
      );

endmodule

//--- source/ex_stage.sv
`timescale 1ns/10ps
`include "rv_ex_cfg.svh"

module ex_stage
  (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   id_ex_if.dst                  exe_i,
   output logic                  res_valid_o,
   output rv_ex_pkg::reg_addr_t  res_wd_o,
   output logic                  res_wreg_o,
   output rv_ex_pkg::word_t      res_wdata_o,
   output rv_ex_pkg::memop_t     mem_op_o,    // none, load, store
   output rv_ex_pkg::word_t      mem_addr_o,
   output rv_ex_pkg::word_t      mem_wdata_o
   );

   import rv_ex_pkg::*;

   logic [4:0] shamt;
   word_t      logic_res;
   word_t      shift_res;
   word_t      sra_mask;
   word_t      arith_res;
   word_t      reg2_mux;
   word_t      sum_res;
   logic       neg_b;
   logic       lt_signed;
   logic       lt_res;
   word_t      wdata_nxt;
   word_t      addr_nxt;
   memop_t     memop_nxt;

   // ####################
   // logic unit
   always_comb
   begin
      case (exe_i.aluop)
         `RV_OP_AND: logic_res = exe_i.reg1 & exe_i.reg2;
         `RV_OP_OR:  logic_res = exe_i.reg1 | exe_i.reg2;
         `RV_OP_XOR: logic_res = exe_i.reg1 ^ exe_i.reg2;
         default:    logic_res = '0;
      endcase
   end

   // ####################
   // shift unit
   assign shamt    = exe_i.reg2[4:0];                          // low 5 bits only
   assign sra_mask = {`RV_XLEN{exe_i.reg1[`RV_XLEN-1]}}
                     & ~({`RV_XLEN{1'b1}} >> shamt);           // sign fill bits

   always_comb
   begin
      case (exe_i.aluop)
         `RV_OP_SLL: shift_res = exe_i.reg1 << shamt;
         `RV_OP_SRL: shift_res = exe_i.reg1 >> shamt;
         `RV_OP_SRA: shift_res = (exe_i.reg1 >> shamt) | sra_mask;
         default:    shift_res = '0;
      endcase
   end

   // ####################
   // arithmetic unit
   assign neg_b     = (exe_i.aluop == `RV_OP_SUB) || (exe_i.aluop == `RV_OP_SLT);
   assign reg2_mux  = neg_b ? (~exe_i.reg2 + `RV_XLEN'd1) : exe_i.reg2; // two's complement
   assign sum_res   = exe_i.reg1 + reg2_mux;
   // a neg and b pos, or same sign and a - b negative
   assign lt_signed = (exe_i.reg1[`RV_XLEN-1] && !exe_i.reg2[`RV_XLEN-1])
                      || ((exe_i.reg1[`RV_XLEN-1] == exe_i.reg2[`RV_XLEN-1])
                          && sum_res[`RV_XLEN-1]);
   assign lt_res    = (exe_i.aluop == `RV_OP_SLT) ? lt_signed
                                                  : (exe_i.reg1 < exe_i.reg2); // sltu

   always_comb
   begin
      case (exe_i.aluop)
         `RV_OP_SLT, `RV_OP_SLTU: arith_res = {{(`RV_XLEN-1){1'b0}}, lt_res};
         `RV_OP_ADD, `RV_OP_SUB:  arith_res = sum_res;
         default:                 arith_res = '0;
      endcase
   end

   // ####################
   // address and result select
   assign addr_nxt = exe_i.reg1 + exe_i.mem_off; // effective address

   always_comb
   begin
      case (exe_i.alusel)
         `RV_RES_LOGIC: wdata_nxt = logic_res;
         `RV_RES_SHIFT: wdata_nxt = shift_res;
         `RV_RES_ARITH: wdata_nxt = arith_res;
         `RV_RES_LINK:  wdata_nxt = exe_i.link_addr;
         default:       wdata_nxt = '0;          // mem, nop
      endcase
   end

   always_comb
   begin
      memop_nxt = `RV_MEM_NONE;
      if (exe_i.valid && exe_i.aluop == `RV_OP_LW)
         memop_nxt = `RV_MEM_LOAD;
      else if (exe_i.valid && exe_i.aluop == `RV_OP_SW)
         memop_nxt = `RV_MEM_STORE;
   end

   // ####################
   // ex/mem boundary
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         res_valid_o <= 1'b0;
         res_wreg_o  <= 1'b0;
         mem_op_o    <= `RV_MEM_NONE;
      end
      else
      begin
         res_valid_o <= exe_i.valid;
         res_wreg_o  <= exe_i.valid && exe_i.wreg; // low on idle cycles
         mem_op_o    <= memop_nxt;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (exe_i.valid)
      begin
         res_wd_o    <= exe_i.wd;
         res_wdata_o <= wdata_nxt;
         mem_addr_o  <= addr_nxt;
         mem_wdata_o <= exe_i.store_data;
      end
   end

endmodule

//--- source/id_ex_reg.sv
`timescale 1ns/10ps
`include "rv_ex_cfg.svh"

module id_ex_reg
  (
   input  logic  clk_i,
   input  logic  rst_n_i,   // sync, active low
   id_ex_if.dst  dec_i,
   id_ex_if.src  exe_o
   );

   // ####################
   // control, cleared by reset
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         exe_o.valid <= 1'b0;
         exe_o.wreg  <= 1'b0;
         exe_o.aluop <= `RV_OP_NOP;
      end
      else
      begin
         exe_o.valid <= dec_i.valid;   // strobe every clock
         if (dec_i.valid)
         begin
            exe_o.wreg  <= dec_i.wreg;
            exe_o.aluop <= dec_i.aluop;
         end
      end
   end

   // ####################
   // payload, loads on valid only, held when idle
   always_ff @(posedge clk_i)
   begin
      if (dec_i.valid)
      begin
         exe_o.alusel     <= dec_i.alusel;
         exe_o.reg1       <= dec_i.reg1;
         exe_o.reg2       <= dec_i.reg2;
         exe_o.wd         <= dec_i.wd;
         exe_o.mem_off    <= dec_i.mem_off;
         exe_o.store_data <= dec_i.store_data;
         exe_o.link_addr  <= dec_i.link_addr;
      end
   end

endmodule

//--- source/id_stage.sv
`timescale 1ns/10ps
`include "rv_ex_cfg.svh"

module id_stage
  (
   input  logic             inst_valid_i, // issue strobe
   input  rv_ex_pkg::word_t inst_i,
   input  rv_ex_pkg::word_t pc_i,
   input  rv_ex_pkg::word_t rs1_data_i,   // operands arrive resolved
   input  rv_ex_pkg::word_t rs2_data_i,
   id_ex_if.src             dec_o
   );

   import rv_ex_pkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   reg_addr_t  rd;
   word_t      imm_i;
   word_t      imm_s;
   word_t      shamt;
   logic       is_imm;
   logic       f7_base;
   logic       f7_alt;

   aluop_t     alu_op;  // from funct3/funct7 only
   alusel_t    alu_sel;
   logic       alu_ok;

   aluop_t     aluop;
   alusel_t    alusel;
   logic       wreg;
   word_t      op2;
   word_t      mem_off;

   // ####################
   // instruction fields
   assign opcode  = inst_i[6:0];
   assign rd      = inst_i[11:7];
   assign funct3  = inst_i[14:12];
   assign funct7  = inst_i[31:25];
   assign imm_i   = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:20]};
   assign imm_s   = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
   assign shamt   = {{(`RV_XLEN-5){1'b0}}, inst_i[24:20]}; // slli/srli/srai
   assign is_imm  = (opcode == `RV_OPC_OP_IMM);
   assign f7_base = (funct7 == 7'b0000000);
   assign f7_alt  = (funct7 == 7'b0100000);     // sub, sra

   // ####################
   // alu op from funct3, shared by r and i forms
   always_comb
   begin
      alu_op  = `RV_OP_NOP;
      alu_sel = `RV_RES_NOP;
      alu_ok  = 1'b0;
      case (funct3)
         3'b000:
         begin
            alu_op  = (!is_imm && f7_alt) ? `RV_OP_SUB : `RV_OP_ADD; // addi has no sub
            alu_sel = `RV_RES_ARITH;
            alu_ok  = is_imm || f7_base || f7_alt;
         end
         3'b001:
         begin
            alu_op  = `RV_OP_SLL;
            alu_sel = `RV_RES_SHIFT;
            alu_ok  = f7_base;                  // funct7 checked in both forms
         end
         3'b010:
         begin
            alu_op  = `RV_OP_SLT;
            alu_sel = `RV_RES_ARITH;
            alu_ok  = is_imm || f7_base;
         end
         3'b011:
         begin
            alu_op  = `RV_OP_SLTU;
            alu_sel = `RV_RES_ARITH;
            alu_ok  = is_imm || f7_base;
         end
         3'b100:
         begin
            alu_op  = `RV_OP_XOR;
            alu_sel = `RV_RES_LOGIC;
            alu_ok  = is_imm || f7_base;
         end
         3'b101:
         begin
            alu_op  = f7_alt ? `RV_OP_SRA : `RV_OP_SRL;
            alu_sel = `RV_RES_SHIFT;
            alu_ok  = f7_base || f7_alt;
         end
         3'b110:
         begin
            alu_op  = `RV_OP_OR;
            alu_sel = `RV_RES_LOGIC;
            alu_ok  = is_imm || f7_base;
         end
         default:
         begin
            alu_op  = `RV_OP_AND;
            alu_sel = `RV_RES_LOGIC;
            alu_ok  = is_imm || f7_base;
         end
      endcase
   end

   // ####################
   // major opcode decode, anything unknown is nop
   always_comb
   begin
      aluop   = `RV_OP_NOP;
      alusel  = `RV_RES_NOP;
      wreg    = 1'b0;
      op2     = rs2_data_i;
      mem_off = '0;
      case (opcode)
         `RV_OPC_OP, `RV_OPC_OP_IMM:
         begin
            if (is_imm)
               op2 = (funct3[1:0] == 2'b01) ? shamt : imm_i; // shifts take shamt
            if (alu_ok)
            begin
               aluop  = alu_op;
               alusel = alu_sel;
               wreg   = 1'b1;
            end
         end
         `RV_OPC_LOAD:
         begin
            if (funct3 == 3'b010)              // lw only
            begin
               aluop   = `RV_OP_LW;
               alusel  = `RV_RES_MEM;          // write data stays zero here
               wreg    = 1'b1;
               mem_off = imm_i;
            end
         end
         `RV_OPC_STORE:
         begin
            if (funct3 == 3'b010)              // sw only
            begin
               aluop   = `RV_OP_SW;
               alusel  = `RV_RES_MEM;
               mem_off = imm_s;                // no register write
            end
         end
         `RV_OPC_JAL, `RV_OPC_JALR:
         begin
            if (opcode == `RV_OPC_JAL || funct3 == 3'b000)
            begin
               aluop  = `RV_OP_JAL;
               alusel = `RV_RES_LINK;          // rd <= pc + 4
               wreg   = 1'b1;
            end
         end
         default:
         begin
            wreg = 1'b0;
         end
      endcase
   end

   assign dec_o.valid      = inst_valid_i; // passes even for nop
   assign dec_o.aluop      = aluop;
   assign dec_o.alusel     = alusel;
   assign dec_o.reg1       = rs1_data_i;
   assign dec_o.reg2       = op2;
   assign dec_o.wd         = rd;
   assign dec_o.wreg       = wreg;
   assign dec_o.mem_off    = mem_off;
   assign dec_o.store_data = rs2_data_i;
   assign dec_o.link_addr  = pc_i + `RV_XLEN'd4;

endmodule

//--- source/id_ex_if.sv
`timescale 1ns/10ps

interface id_ex_if;

   import rv_ex_pkg::*;

   logic      valid;      // one-cycle strobe, no ready
   aluop_t    aluop;
   alusel_t   alusel;
   word_t     reg1;       // operand a
   word_t     reg2;       // operand b, reg or imm
   reg_addr_t wd;         // destination
   logic      wreg;       // write enable
   word_t     mem_off;    // i-form or s-form offset
   word_t     store_data; // rs2 value for sw
   word_t     link_addr;  // pc + 4

   // sending side
   modport src (
      output valid, aluop, alusel, reg1, reg2,
      output wd, wreg, mem_off, store_data, link_addr
   );

   // receiving side
   modport dst (
      input  valid, aluop, alusel, reg1, reg2,
      input  wd, wreg, mem_off, store_data, link_addr
   );

endinterface

//--- source/rv_ex_pkg.sv
`include "rv_ex_cfg.svh"

package rv_ex_pkg;

   // ####################
   // data path widths
   typedef logic [`RV_XLEN-1:0]     word_t;     // one data word
   typedef logic [`RV_REG_AW-1:0]   reg_addr_t; // register index

   // ####################
   // control fields
   typedef logic [`RV_ALUOP_W-1:0]  aluop_t;    // operation code
   typedef logic [`RV_ALUSEL_W-1:0] alusel_t;   // result class
   typedef logic [`RV_MEMOP_W-1:0]  memop_t;    // none, load, store

endpackage

//--- source/rv_ex_cfg.svh
`ifndef RV_EX_CFG_SVH
`define RV_EX_CFG_SVH

`define RV_XLEN      32            // data word width
`define RV_REG_AW    5             // x0..x31
`define RV_ALUOP_W   8
`define RV_ALUSEL_W  3
`define RV_MEMOP_W   2

// ####################
// operation codes
`define RV_OP_NOP    8'b0000_0000
`define RV_OP_AND    8'b0010_0100
`define RV_OP_OR     8'b0010_0101
`define RV_OP_XOR    8'b0010_0110
`define RV_OP_SLL    8'b0111_1100
`define RV_OP_SRL    8'b0000_0010
`define RV_OP_SRA    8'b0000_0011
`define RV_OP_ADD    8'b0010_0000
`define RV_OP_SUB    8'b0010_0010
`define RV_OP_SLT    8'b0010_1010
`define RV_OP_SLTU   8'b0010_1011
`define RV_OP_LW     8'b1110_0011
`define RV_OP_SW     8'b1110_1011
`define RV_OP_JAL    8'b0101_0000

// ####################
// result classes
`define RV_RES_NOP   3'b000
`define RV_RES_LOGIC 3'b001
`define RV_RES_SHIFT 3'b010
`define RV_RES_ARITH 3'b100
`define RV_RES_LINK  3'b110
`define RV_RES_MEM   3'b111

// memory operation on the ex/mem boundary
`define RV_MEM_NONE  2'b00
`define RV_MEM_LOAD  2'b01
`define RV_MEM_STORE 2'b10

// rv32i major opcodes
`define RV_OPC_OP     7'b0110011
`define RV_OPC_OP_IMM 7'b0010011
`define RV_OPC_LOAD   7'b0000011
`define RV_OPC_STORE  7'b0100011
`define RV_OPC_JAL    7'b1101111
`define RV_OPC_JALR   7'b1100111

`endif
